// File: compile.f
+incdir+rtl
rtl/dispatch_pkg.sv
rtl/instr_decoder.sv
rtl/reg_status_table.sv
rtl/dispatch_stage.sv
rtl/dispatch_top.sv
tb/dispatch_tb.sv

// File: Bender.yml
package:
  name: dispatch

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dispatch_pkg.sv
      - rtl/instr_decoder.sv
      - rtl/reg_status_table.sv
      - rtl/dispatch_stage.sv
      - rtl/dispatch_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/dispatch_tb.sv

// File: tb/dispatch_tb.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module dispatch_tb import dispatch_pkg::*; ();

    localparam int PERIOD = 100;

    // control bits of a step: scalar wb, matrix wb, resolve, miss
    localparam logic [3:0] CTL_S_WB = 4'b1000;
    localparam logic [3:0] CTL_M_WB = 4'b0100;
    localparam logic [3:0] CTL_RES  = 4'b0010;
    localparam logic [3:0] CTL_MISS = 4'b0001;

    typedef struct packed {
        logic [31:0] instr;
        logic [4:0]  busy;
        logic [3:0]  ctl;
        logic [4:0]  wb_sel;
        logic        frz;
        fu_class_t   cls;
        logic [31:0] rd;
        logic [31:0] imm;
        tag_t        t1;
        tag_t        t2;
        tag_t        t3;
        logic        sp;
        logic        jp;
        fu_s_t       fs;
        logic [3:0]  op;
        logic        hlt;
    } step_t;

    logic        CLK;
    logic        nRST;
    logic        instr_valid;
    logic [31:0] instr;
    logic [4:0]  fu_busy;
    logic        s_wb_en;
    s_reg_t      s_wb_sel;
    logic        m_wb_en;
    m_reg_t      m_wb_sel;
    logic        branch_resolved;
    logic        branch_miss;
    logic        freeze;
    logic        s_issue;
    logic        m_issue;
    logic        g_issue;
    fu_s_t       issue_fu_s;
    logic [4:0]  issue_rd;
    logic [31:0] issue_imm;
    logic [3:0]  issue_op;
    tag_t        issue_t1;
    tag_t        issue_t2;
    tag_t        issue_t3;
    logic        spec_out;
    logic        jump_pending;
    logic        halt_out;

    step_t steps [$];
    string names [$];
    int    n_steps = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    logic  step_bad;

    dispatch_top u_dispatch_top (.*);

    always #(PERIOD / 2) CLK = ~CLK;

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [4:0] rd, rs1, rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, `DISP_OP_ALU};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [4:0] rs1, rs2,
                                           input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], `DISP_OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `DISP_OP_JAL};
    endfunction

    function automatic logic [31:0] gemm(input logic [3:0] md, ms1, ms2, ms3);
        return {md, ms1, ms2, ms3, 9'b0, `DISP_OP_GEMM};
    endfunction

    // scalar base sits in bits 19:15
    function automatic logic [31:0] mload(input logic [3:0] md, input logic [4:0] base);
        return {md, 8'b0, base, 8'b0, `DISP_OP_MLOAD};
    endfunction

    task automatic add_step(input string name, input logic [31:0] ins, input logic [4:0] busy,
                            input logic [3:0] ctl, input logic [4:0] wb_sel, input logic frz,
                            input fu_class_t cls, input logic [31:0] rd,
                            input logic [31:0] imm, input tag_t t1, input tag_t t2,
                            input tag_t t3, input logic sp, input logic jp,
                            input fu_s_t fs, input logic [3:0] op, input logic hlt);
        step_t s;
        s = '{ins, busy, ctl, wb_sel, frz, cls, rd, imm, t1, t2, t3, sp, jp, fs, op, hlt};
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic build_table();
        add_step("alu x5", r_type(5, 1, 2), 0, 0, 0, 0, FU_SCALAR, 5, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("read x5", r_type(7, 5, 3), 0, 0, 0, 0, FU_SCALAR, 7, 0, 1, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("load x6", i_type(`DISP_OP_LOAD, 6, 1, 3'd2, 12'd8), 0, 0, 0, 0,
                 FU_SCALAR, 6, 8, 0, 0, 0, 0, 0, FU_S_LD_ST, 2, 0);
        add_step("read x6 x5", r_type(8, 6, 5), 0, 0, 0, 0, FU_SCALAR, 8, 0, 2, 1, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        // waw on x5, busy until the edge after its writeback
        add_step("waw x5", r_type(5, 1, 2), 0, 0, 0, 1, FU_NONE, 0, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("waw x5 wb", r_type(5, 1, 2), 0, CTL_S_WB, 5, 1, FU_NONE, 0, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("x5 issues", r_type(5, 1, 2), 0, 0, 0, 0, FU_SCALAR, 5, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("alu busy", i_type(`DISP_OP_ALUI, 10, 0, 3'd0, -12'sd3), 5'b00001, 0, 0, 1,
                 FU_NONE, 0, 0, 0, 0, 0, 0, 0, FU_S_ALU, 0, 0);
        add_step("alu free", i_type(`DISP_OP_ALUI, 10, 0, 3'd0, -12'sd3), 0, 0, 0, 0,
                 FU_SCALAR, 10, 32'hffff_fffd, 0, 0, 0, 0, 0, FU_S_ALU, 0, 0);
        // offset 32 leaves the rd field zero
        add_step("beq", b_type(1, 2, 13'd32), 0, 0, 0, 0, FU_SCALAR, 0, 32, 0, 0, 0, 0, 0,
                 FU_S_BRANCH, 0, 0);
        add_step("spec x9", r_type(9, 1, 2), 0, 0, 0, 0, FU_SCALAR, 9, 0, 0, 0, 0, 1, 0,
                 FU_S_ALU, 0, 0);
        add_step("miss", r_type(11, 1, 2), 0, CTL_MISS, 0, 0, FU_NONE, 0, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("x9 released", r_type(9, 1, 2), 0, 0, 0, 0, FU_SCALAR, 9, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        // matrix side, base x5 still held by the alu
        add_step("mload m3", mload(3, 5), 0, 0, 0, 0, FU_MLOAD, 3, 0, 1, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("gemm m4", gemm(4, 3, 1, 2), 0, 0, 0, 0, FU_GEMM, 4, 0, 2, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("gemm waw m3", gemm(3, 1, 2, 5), 0, 0, 0, 1, FU_NONE, 0, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("gemm m3 wb", gemm(3, 1, 2, 5), 0, CTL_M_WB, 3, 1, FU_NONE,
                 0, 0, 0, 0, 0, 0, 0, FU_S_ALU, 0, 0);
        add_step("gemm m3", gemm(3, 1, 2, 5), 0, 0, 0, 0, FU_GEMM, 3, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("jal x12", j_type(12, 21'd8), 0, 0, 0, 0, FU_SCALAR, 12, 8, 0, 0, 0, 0, 1,
                 FU_S_BRANCH, 0, 0);
        add_step("resolve", 32'd0, 0, CTL_RES, 0, 0, FU_NONE, 0, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 0);
        add_step("halt", {25'd0, `DISP_OP_HALT}, 0, 0, 0, 0, FU_NONE, 0, 0, 0, 0, 0, 0, 0,
                 FU_S_ALU, 0, 1);
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", sig, got, exp);
            errors++;
            step_bad = 1'b1;
        end
    endtask

    task automatic check_tag(input string sig, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", sig, got, exp);
            errors++;
            step_bad = 1'b1;
        end
    endtask

    task automatic check_fu_s(input string sig, input fu_s_t got, input fu_s_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", sig, got, exp);
            errors++;
            step_bad = 1'b1;
        end
    endtask

    task automatic check_word(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", sig, got, exp);
            errors++;
            step_bad = 1'b1;
        end
    endtask

    task automatic apply(input step_t s);
        instr_valid     = (s.instr != '0);
        instr           = s.instr;
        fu_busy         = s.busy;
        s_wb_en         = s.ctl[3];
        m_wb_en         = s.ctl[2];
        s_wb_sel        = s.wb_sel;
        m_wb_sel        = s.wb_sel[3:0];
        branch_resolved = s.ctl[1];
        branch_miss     = s.ctl[0];
    endtask

    task automatic check_outputs(input step_t s);
        check_bit("s_issue", s_issue, s.cls == FU_SCALAR);
        check_bit("m_issue", m_issue, s.cls == FU_MLOAD);
        check_bit("g_issue", g_issue, s.cls == FU_GEMM);
        check_bit("spec_out", spec_out, s.sp);
        check_bit("jump_pending", jump_pending, s.jp);
        check_bit("halt_out", halt_out, s.hlt);
        if (s.cls != FU_NONE) begin
            check_word("issue_rd", 32'(issue_rd), s.rd);
            check_word("issue_imm", issue_imm, s.imm);
            check_tag("issue_t1", issue_t1, s.t1);
            check_tag("issue_t2", issue_t2, s.t2);
            check_tag("issue_t3", issue_t3, s.t3);
        end
        // unit and function code only defined on the scalar side
        if (s.cls == FU_SCALAR) begin
            check_fu_s("issue_fu_s", issue_fu_s, s.fs);
            check_word("issue_op", 32'(issue_op), 32'(s.op));
        end
    endtask

    task automatic report_step(input string name);
        tests_run++;
        if (step_bad) begin
            tests_failed++;
        end
        $display("test %0d %0s: %0s", tests_run, name, step_bad ? "mismatch" : "ok");
    endtask

    // budget of four cycles per step on top of reset
    initial begin
        wait (n_steps > 0);
        #((n_steps * 4 + 16) * PERIOD);
        $display("timeout: the run did not finish within its cycle budget");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        step_t s;
        CLK             = 1'b0;
        nRST            = 1'b0;
        instr_valid     = 1'b0;
        instr           = '0;
        fu_busy         = '0;
        s_wb_en         = 1'b0;
        s_wb_sel        = '0;
        m_wb_en         = 1'b0;
        m_wb_sel        = '0;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        build_table();
        n_steps = steps.size();
        repeat (16) @(posedge CLK);
        #5 nRST = 1'b1;

        // idle state straight after reset
        step_bad = 1'b0;
        @(negedge CLK);
        check_bit("freeze", freeze, 1'b0);
        check_bit("s_issue", s_issue, 1'b0);
        check_bit("m_issue", m_issue, 1'b0);
        check_bit("g_issue", g_issue, 1'b0);
        check_bit("spec_out", spec_out, 1'b0);
        check_bit("jump_pending", jump_pending, 1'b0);
        check_bit("halt_out", halt_out, 1'b0);
        report_step("reset");
        @(posedge CLK);
        #5;

        for (int i = 0; i < n_steps; i++) begin
            s = steps[i];
            step_bad = 1'b0;
            apply(s);
            // freeze is combinational, sample mid cycle
            @(negedge CLK);
            check_bit("freeze", freeze, s.frz);
            @(posedge CLK);
            #1;
            check_outputs(s);
            report_step(names[i]);
            #4;
        end

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/dispatch_top.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module dispatch_top import dispatch_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    instr_valid,
    input  logic [`DISP_WORD_W-1:0] instr,
    input  logic [4:0]              fu_busy,
    input  logic                    s_wb_en,
    input  s_reg_t                  s_wb_sel,
    input  logic                    m_wb_en,
    input  m_reg_t                  m_wb_sel,
    input  logic                    branch_resolved,
    input  logic                    branch_miss,
    output logic                    freeze,
    output logic                    s_issue,
    output logic                    m_issue,
    output logic                    g_issue,
    output fu_s_t                   issue_fu_s,
    output logic [4:0]              issue_rd,
    output logic [31:0]             issue_imm,
    output logic [3:0]              issue_op,
    output tag_t                    issue_t1,
    output tag_t                    issue_t2,
    output tag_t                    issue_t3,
    output logic                    spec_out,
    output logic                    jump_pending,
    output logic                    halt_out
);

    fu_class_t   fu_class;
    fu_s_t       fu_s;
    logic        s_reg_write, m_reg_write, is_branch, is_jump, halt;
    logic [31:0] imm;
    logic [3:0]  op;

    logic        s_di_write, m_di_write, di_spec, s_rd_busy, m_rd_busy;
    s_reg_t      s_di_sel, s_rd_sel;
    m_reg_t      m_di_sel, m_rd_sel;
    tag_t        s_di_tag, m_di_tag;
    s_reg_t      s_src_sel [3];
    m_reg_t      m_src_sel [3];
    tag_t        s_src_tag [3];
    tag_t        m_src_tag [3];

    instr_decoder u_dec (.*);

    dispatch_stage u_stage (.*);

    reg_status_table #(.sel_t(s_reg_t)) u_s_rst (
        .CLK(CLK), .nRST(nRST),
        .di_write(s_di_write), .di_sel(s_di_sel), .di_tag(s_di_tag), .di_spec(di_spec),
        .wb_write(s_wb_en), .wb_sel(s_wb_sel),
        .flush(branch_miss), .resolved(branch_resolved),
        .rd_sel(s_rd_sel), .src_sel(s_src_sel),
        .rd_busy(s_rd_busy), .src_tag(s_src_tag)
    );

    reg_status_table #(.sel_t(m_reg_t)) u_m_rst (
        .CLK(CLK), .nRST(nRST),
        .di_write(m_di_write), .di_sel(m_di_sel), .di_tag(m_di_tag), .di_spec(di_spec),
        .wb_write(m_wb_en), .wb_sel(m_wb_sel),
        .flush(branch_miss), .resolved(branch_resolved),
        .rd_sel(m_rd_sel), .src_sel(m_src_sel),
        .rd_busy(m_rd_busy), .src_tag(m_src_tag)
    );

endmodule

// File: rtl/dispatch_stage.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module dispatch_stage import dispatch_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    instr_valid,
    input  logic [`DISP_WORD_W-1:0] instr,
    input  fu_class_t               fu_class,
    input  fu_s_t                   fu_s,
    input  logic                    s_reg_write,
    input  logic                    m_reg_write,
    input  logic                    is_branch,
    input  logic                    is_jump,
    input  logic                    halt,
    input  logic [31:0]             imm,
    input  logic [3:0]              op,
    input  logic [4:0]              fu_busy,
    input  logic                    branch_resolved,
    input  logic                    branch_miss,
    input  logic                    s_rd_busy,
    input  logic                    m_rd_busy,
    input  tag_t                    s_src_tag [3],
    input  tag_t                    m_src_tag [3],
    output logic                    s_di_write,
    output logic                    m_di_write,
    output s_reg_t                  s_di_sel,
    output m_reg_t                  m_di_sel,
    output tag_t                    s_di_tag,
    output tag_t                    m_di_tag,
    output logic                    di_spec,
    output s_reg_t                  s_src_sel [3],
    output m_reg_t                  m_src_sel [3],
    output s_reg_t                  s_rd_sel,
    output m_reg_t                  m_rd_sel,
    output logic                    freeze,
    output logic                    s_issue,
    output logic                    m_issue,
    output logic                    g_issue,
    output fu_s_t                   issue_fu_s,
    output logic [4:0]              issue_rd,
    output logic [31:0]             issue_imm,
    output logic [3:0]              issue_op,
    output tag_t                    issue_t1,
    output tag_t                    issue_t2,
    output tag_t                    issue_t3,
    output logic                    spec_out,
    output logic                    jump_pending,
    output logic                    halt_out
);

    s_reg_t s_rd;
    m_reg_t m_rd;
    logic   s_wr;
    logic   uses_rs2;
    logic   struct_haz;
    logic   waw;
    logic   accept;
    logic   spec;
    logic   [4:0] n_rd;
    tag_t   n_t1, n_t2, n_t3;

    assign s_rd = instr[11:7];
    assign m_rd = instr[31:28];

    // x0 is never reserved
    assign s_wr = s_reg_write && (s_rd != '0);
    assign uses_rs2 = (instr[6:0] == `DISP_OP_ALU) || (instr[6:0] == `DISP_OP_STORE) ||
                      (instr[6:0] == `DISP_OP_BRANCH);

    // lookups, matrix base shares the rs1 field
    assign s_rd_sel     = s_rd;
    assign s_src_sel[0] = instr[19:15];
    assign s_src_sel[1] = instr[24:20];
    assign s_src_sel[2] = '0;
    assign m_rd_sel     = m_rd;
    assign m_src_sel[0] = instr[27:24];
    assign m_src_sel[1] = instr[23:20];
    assign m_src_sel[2] = instr[19:16];

    always_comb begin
        case (fu_class)
            FU_SCALAR: struct_haz = fu_busy[fu_s];
            FU_MLOAD:  struct_haz = fu_busy[FUB_MLOAD];
            FU_GEMM:   struct_haz = fu_busy[FUB_GEMM];
            default:   struct_haz = 1'b0;
        endcase
    end

    assign waw    = (s_wr && s_rd_busy) || (m_reg_write && m_rd_busy);
    assign freeze = instr_valid && (struct_haz || waw);
    assign accept = instr_valid && !struct_haz && !waw && !branch_miss;

    // reservations
    assign s_di_write = accept && s_wr;
    assign s_di_sel   = s_rd;
    assign s_di_tag   = (fu_s == FU_S_LD_ST)  ? `DISP_TAG_LD :
                        (fu_s == FU_S_BRANCH) ? `DISP_TAG_BR : `DISP_TAG_ALU;
    assign m_di_write = accept && m_reg_write;
    assign m_di_sel   = m_rd;
    // gemm results carry the alu tag
    assign m_di_tag   = (fu_class == FU_MLOAD) ? `DISP_TAG_LD : `DISP_TAG_ALU;
    assign di_spec    = spec && !branch_resolved;

    // operand tags per class
    always_comb begin
        n_rd = {1'b0, m_rd};
        n_t1 = '0;
        n_t2 = '0;
        n_t3 = '0;
        case (fu_class)
            FU_SCALAR: begin
                n_rd = s_rd;
                n_t1 = is_jump ? '0 : s_src_tag[0];
                n_t2 = uses_rs2 ? s_src_tag[1] : '0;
            end
            FU_MLOAD: n_t1 = s_src_tag[0];
            FU_GEMM: begin
                n_t1 = m_src_tag[0];
                n_t2 = m_src_tag[1];
                n_t3 = m_src_tag[2];
            end
            default: ;
        endcase
    end

    // issue register, squash first
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            s_issue    <= 1'b0;
            m_issue    <= 1'b0;
            g_issue    <= 1'b0;
            issue_fu_s <= FU_S_ALU;
            issue_rd   <= '0;
            issue_imm  <= '0;
            issue_op   <= '0;
            issue_t1   <= '0;
            issue_t2   <= '0;
            issue_t3   <= '0;
            spec_out   <= 1'b0;
            halt_out   <= 1'b0;
        end else if (branch_miss) begin
            s_issue    <= 1'b0;
            m_issue    <= 1'b0;
            g_issue    <= 1'b0;
            issue_fu_s <= FU_S_ALU;
            issue_rd   <= '0;
            issue_imm  <= '0;
            issue_op   <= '0;
            issue_t1   <= '0;
            issue_t2   <= '0;
            issue_t3   <= '0;
            spec_out   <= 1'b0;
            halt_out   <= 1'b0;
        end else begin
            s_issue  <= accept && (fu_class == FU_SCALAR);
            m_issue  <= accept && (fu_class == FU_MLOAD);
            g_issue  <= accept && (fu_class == FU_GEMM);
            spec_out <= accept && di_spec;
            halt_out <= accept && halt;
            if (accept) begin
                issue_fu_s <= fu_s;
                issue_rd   <= n_rd;
                issue_imm  <= imm;
                issue_op   <= op;
                issue_t1   <= n_t1;
                issue_t2   <= n_t2;
                issue_t3   <= n_t3;
            end
        end
    end

    // speculation and jump state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec         <= 1'b0;
            jump_pending <= 1'b0;
        end else if (branch_miss) begin
            spec         <= 1'b0;
            jump_pending <= 1'b0;
        end else begin
            if (accept && is_branch) begin
                spec <= 1'b1;
            end else if (branch_resolved) begin
                spec <= 1'b0;
            end
            if (accept && is_jump) begin
                jump_pending <= 1'b1;
            end else if (branch_resolved) begin
                jump_pending <= 1'b0;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({s_issue, m_issue, g_issue}));

endmodule

// File: rtl/reg_status_table.sv
`timescale 1ns/1ps

module reg_status_table import dispatch_pkg::*; #(
    parameter type sel_t = logic [4:0]
) (
    input  logic CLK,
    input  logic nRST,
    input  logic di_write,
    input  sel_t di_sel,
    input  tag_t di_tag,
    input  logic di_spec,
    input  logic wb_write,
    input  sel_t wb_sel,
    input  logic flush,
    input  logic resolved,
    input  sel_t rd_sel,
    input  sel_t src_sel [3],
    output logic rd_busy,
    output tag_t src_tag [3]
);

    localparam int N = 2 ** $bits(sel_t);

    logic busy [N];
    logic spec [N];
    tag_t tag  [N];

    // busy and spec per entry, dispatch write beats writeback
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N; i++) begin
                busy[i] <= 1'b0;
                spec[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (di_write && di_sel == sel_t'(i)) begin
                    busy[i] <= 1'b1;
                    spec[i] <= di_spec;
                end else if (flush && spec[i]) begin
                    // squashed reservation
                    busy[i] <= 1'b0;
                    spec[i] <= 1'b0;
                end else if (wb_write && wb_sel == sel_t'(i)) begin
                    busy[i] <= 1'b0;
                    spec[i] <= 1'b0;
                end else if (resolved) begin
                    spec[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (di_write) begin
            tag[di_sel] <= di_tag;
        end
    end

    // lookups, idle registers read as ready
    assign rd_busy = busy[rd_sel];

    always_comb begin
        for (int k = 0; k < 3; k++) begin
            src_tag[k] = busy[src_sel[k]] ? tag[src_sel[k]] : '0;
        end
    end

    // the stage must not reserve in a squash cycle
    assert property (@(posedge CLK) disable iff (!nRST) !(di_write && flush));

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module instr_decoder import dispatch_pkg::*; (
    input  logic [`DISP_WORD_W-1:0] instr,
    output fu_class_t               fu_class,
    output fu_s_t                   fu_s,
    output logic                    s_reg_write,
    output logic                    m_reg_write,
    output logic                    is_branch,
    output logic                    is_jump,
    output logic                    halt,
    output logic [31:0]             imm,
    output logic [3:0]              op
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        fu_class    = FU_NONE;
        fu_s        = FU_S_ALU;
        s_reg_write = 1'b0;
        m_reg_write = 1'b0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        halt        = 1'b0;
        imm         = '0;
        op          = '0;
        case (opcode)
            `DISP_OP_ALU: begin
                fu_class    = FU_SCALAR;
                s_reg_write = 1'b1;
                op          = {instr[30], funct3};
            end
            `DISP_OP_ALUI: begin
                fu_class    = FU_SCALAR;
                s_reg_write = 1'b1;
                imm         = {{20{instr[31]}}, instr[31:20]};
                // only shift-right immediates carry the funct7 bit
                op          = {(funct3 == 3'b101) & instr[30], funct3};
            end
            `DISP_OP_LOAD: begin
                fu_class    = FU_SCALAR;
                fu_s        = FU_S_LD_ST;
                s_reg_write = 1'b1;
                imm         = {{20{instr[31]}}, instr[31:20]};
                op          = {1'b0, funct3};
            end
            `DISP_OP_STORE: begin
                fu_class = FU_SCALAR;
                fu_s     = FU_S_LD_ST;
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                op       = {1'b1, funct3};
            end
            `DISP_OP_BRANCH: begin
                fu_class  = FU_SCALAR;
                fu_s      = FU_S_BRANCH;
                is_branch = 1'b1;
                imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
                op        = {1'b0, funct3};
            end
            `DISP_OP_JAL: begin
                // link register is written by the branch unit
                fu_class    = FU_SCALAR;
                fu_s        = FU_S_BRANCH;
                s_reg_write = 1'b1;
                is_jump     = 1'b1;
                imm         = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
            end
            `DISP_OP_MLOAD: begin
                fu_class    = FU_MLOAD;
                m_reg_write = 1'b1;
                // row stride offset
                imm         = {{24{instr[27]}}, instr[27:20]};
            end
            `DISP_OP_GEMM: begin
                fu_class    = FU_GEMM;
                m_reg_write = 1'b1;
            end
            `DISP_OP_HALT: halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: rtl/dispatch_pkg.sv
`include "dispatch_macros.svh"

package dispatch_pkg;

    // unit class an instruction is sent to
    typedef enum logic [1:0] {
        FU_NONE   = 2'd0,
        FU_SCALAR = 2'd1,
        FU_MLOAD  = 2'd2,
        FU_GEMM   = 2'd3
    } fu_class_t;

    // scalar units, values match their fu_busy bit
    typedef enum logic [1:0] {
        FU_S_ALU    = 2'd0,
        FU_S_LD_ST  = 2'd1,
        FU_S_BRANCH = 2'd2
    } fu_s_t;

    // fu_busy bits of the matrix side
    localparam int FUB_MLOAD = 3;
    localparam int FUB_GEMM  = 4;

    // producer tag
    typedef logic [1:0] tag_t;

    // register selects
    typedef logic [$clog2(`DISP_S_REGS)-1:0] s_reg_t;
    typedef logic [$clog2(`DISP_M_REGS)-1:0] m_reg_t;

endpackage

// File: rtl/dispatch_macros.svh
`ifndef DISPATCH_MACROS_SVH
`define DISPATCH_MACROS_SVH

// instruction word and register file sizes
`define DISP_WORD_W 32
`define DISP_S_REGS 32
`define DISP_M_REGS 16

// major opcodes, bits 6:0
`define DISP_OP_ALU    7'b0110011
`define DISP_OP_ALUI   7'b0010011
`define DISP_OP_LOAD   7'b0000011
`define DISP_OP_STORE  7'b0100011
`define DISP_OP_BRANCH 7'b1100011
`define DISP_OP_JAL    7'b1101111
`define DISP_OP_MLOAD  7'b0000111
`define DISP_OP_GEMM   7'b1110111
`define DISP_OP_HALT   7'b1111111

// producer tags, 0 means operand ready
`define DISP_TAG_ALU 2'd1
`define DISP_TAG_LD  2'd2
`define DISP_TAG_BR  2'd3

`endif
